// File: common/cl_hello_pkg.sv
// Hello world shared definitions

package cl_hello_pkg;

  // ------------------------------------------------------------------------
  // Bus widths
  // ------------------------------------------------------------------------
  localparam int OCL_ADDR_W = 32;
  localparam int OCL_DATA_W = 32;
  localparam int VLED_W     = 16;

  // Byte address on the OCL bus
  typedef logic [OCL_ADDR_W-1:0] ocl_addr_t;

  // Single data beat
  typedef logic [OCL_DATA_W-1:0] ocl_data_t;

  // Virtual LED and DIP switch bits
  typedef logic [VLED_W-1:0] led_t;

  // ------------------------------------------------------------------------
  // Register map
  // ------------------------------------------------------------------------
  // Hello world register, reads back byte swapped
  localparam ocl_addr_t HELLO_WORLD_REG_ADDR = 32'h0000_0500;

  // LED shadow register, read only
  localparam ocl_addr_t VLED_REG_ADDR = 32'h0000_0504;

  // ------------------------------------------------------------------------
  // Write channel FSM
  // ------------------------------------------------------------------------
  // WR_IDLE waits for an address
  // WR_DATA waits for the data beat
  // WR_RESP holds bvalid until bready
  typedef enum logic [1:0] {
    WR_IDLE = 2'd0,
    WR_DATA = 2'd1,
    WR_RESP = 2'd2
  } wr_state_e;

endpackage

// File: ocl/ocl_slave.sv
// OCL single beat bus slave

`timescale 1ns/1ps

module ocl_slave
  import cl_hello_pkg::*;
(
  input  logic      clk_main_a0,
  input  logic      rst_main_n_sync,
  // Write address channel
  input  logic      awvalid,
  input  ocl_addr_t awaddr,
  output logic      awready,
  // Write data channel
  input  logic      wvalid,
  input  ocl_data_t wdata,
  output logic      wready,
  // Write response channel
  output logic      bvalid,
  input  logic      bready,
  // Read address channel
  input  logic      arvalid,
  input  ocl_addr_t araddr,
  output logic      arready,
  // Read data channel
  output logic      rvalid,
  output ocl_data_t rdata,
  input  logic      rready,
  // Register file strobes
  output logic      wr_en,
  output ocl_addr_t wr_addr,
  output ocl_data_t wr_data,
  output ocl_addr_t rd_addr,
  input  ocl_data_t rd_data
);

  // ------------------------------------------------------------------------
  // Write channel
  // ------------------------------------------------------------------------
  wr_state_e wr_state;
  wr_state_e wr_state_nxt;
  ocl_addr_t wr_addr_q;

  // Next state
  always_comb
  begin
    wr_state_nxt = wr_state;
    unique case (wr_state)
      WR_IDLE:
      begin
        if (awvalid)
          wr_state_nxt = WR_DATA;
      end
      WR_DATA:
      begin
        if (wvalid)
          wr_state_nxt = WR_RESP;
      end
      WR_RESP:
      begin
        if (bready)
          wr_state_nxt = WR_IDLE;
      end
      default:
      begin
        wr_state_nxt = WR_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
      wr_state <= WR_IDLE;
    else
      wr_state <= wr_state_nxt;
  end

  // Address is captured on the accepting edge
  always_ff @(posedge clk_main_a0)
  begin
    if (awvalid && awready)
      wr_addr_q <= awaddr;
  end

  assign awready = (wr_state == WR_IDLE);
  assign wready  = (wr_state == WR_DATA) && wvalid;
  assign bvalid  = (wr_state == WR_RESP);

  // Strobe fires with the data beat itself
  assign wr_en   = wready;
  assign wr_addr = wr_addr_q;
  assign wr_data = wdata;

  // ------------------------------------------------------------------------
  // Read channel
  // ------------------------------------------------------------------------
  logic      rd_pend;
  ocl_addr_t rd_addr_q;

  // One read in flight at a time
  assign arready = !rd_pend && !rvalid;

  always_ff @(posedge clk_main_a0)
  begin
    if (arvalid && arready)
      rd_addr_q <= araddr;
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      rd_pend <= 1'b0;
      rvalid  <= 1'b0;
      rdata   <= '0;
    end
    else
    begin
      // Address registered, fetch next cycle
      if (arvalid && arready)
        rd_pend <= 1'b1;
      else if (rd_pend)
        rd_pend <= 1'b0;

      // Data held until the master takes it
      if (rd_pend)
      begin
        rvalid <= 1'b1;
        rdata  <= rd_data;
      end
      else if (rvalid && rready)
        rvalid <= 1'b0;
    end
  end

  assign rd_addr = rd_addr_q;

endmodule

// File: src/hello_world_reg.sv
// Hello world register file

`timescale 1ns/1ps

module hello_world_reg
  import cl_hello_pkg::*;
#(
  parameter int LED_W = 16
) (
  input  logic             clk_main_a0,
  input  logic             rst_main_n_sync,
  input  logic             wr_en,
  input  ocl_addr_t        wr_addr,
  input  ocl_data_t        wr_data,
  input  ocl_addr_t        rd_addr,
  output ocl_data_t        rd_data,
  output logic [LED_W-1:0] led_shadow
);

  ocl_data_t        hello_world_q;
  ocl_data_t        hello_world_swap;
  logic [LED_W-1:0] led_shadow_q;

  // ------------------------------------------------------------------------
  // Register updates
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      hello_world_q <= '0;
      led_shadow_q  <= '0;
    end
    else
    begin
      // Only the hello world address is writable
      if (wr_en && (wr_addr == HELLO_WORLD_REG_ADDR))
        hello_world_q <= wr_data;
      // Shadow trails the main register by one cycle
      led_shadow_q <= hello_world_q[LED_W-1:0];
    end
  end

  // Byte order reversed on read
  assign hello_world_swap = {hello_world_q[7:0], hello_world_q[15:8],
                             hello_world_q[23:16], hello_world_q[31:24]};

  // ------------------------------------------------------------------------
  // Read decode
  // ------------------------------------------------------------------------
  always_comb
  begin
    unique case (rd_addr)
      HELLO_WORLD_REG_ADDR: rd_data = hello_world_swap;
      VLED_REG_ADDR:        rd_data = ocl_data_t'(led_shadow_q);
      // Unmapped reads complete with zero
      default:              rd_data = '0;
    endcase
  end

  assign led_shadow = led_shadow_q;

endmodule

// File: src/vled_status.sv
// Virtual LED status

`timescale 1ns/1ps

module vled_status
  import cl_hello_pkg::*;
#(
  parameter int LED_W = 16
) (
  input  logic             clk_main_a0,
  input  logic             rst_main_n_sync,
  input  logic [LED_W-1:0] led_shadow,
  input  logic [LED_W-1:0] vdip,
  output logic [LED_W-1:0] vled
);

  // ------------------------------------------------------------------------
  // DIP switch synchronizer
  // ------------------------------------------------------------------------
  logic [LED_W-1:0] vdip_q1;
  logic [LED_W-1:0] vdip_q2;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      vdip_q1 <= '0;
      vdip_q2 <= '0;
    end
    else
    begin
      vdip_q1 <= vdip;
      vdip_q2 <= vdip_q1;
    end
  end

  // ------------------------------------------------------------------------
  // LED output register
  // ------------------------------------------------------------------------
  // An LED is lit only when its DIP switch is on
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
      vled <= '0;
    else
      vled <= led_shadow & vdip_q2;
  end

endmodule

// File: src/cl_hello_top.sv
// Hello world top level

`timescale 1ns/1ps

module cl_hello_top
  import cl_hello_pkg::*;
(
  input  logic      clk_main_a0,
  input  logic      rst_main_n_sync,
  // Write address channel
  input  logic      awvalid,
  input  ocl_addr_t awaddr,
  output logic      awready,
  // Write data channel
  input  logic      wvalid,
  input  ocl_data_t wdata,
  output logic      wready,
  // Write response channel
  output logic      bvalid,
  input  logic      bready,
  // Read address channel
  input  logic      arvalid,
  input  ocl_addr_t araddr,
  output logic      arready,
  // Read data channel
  output logic      rvalid,
  output ocl_data_t rdata,
  input  logic      rready,
  // Virtual DIP switches and LEDs
  input  led_t      vdip,
  output led_t      vled
);

  // LED width follows the package LED type
  localparam int LED_W = $bits(led_t);

  // ------------------------------------------------------------------------
  // Register strobes between bus slave and register file
  // ------------------------------------------------------------------------
  logic      wr_en;
  ocl_addr_t wr_addr;
  ocl_data_t wr_data;
  ocl_addr_t rd_addr;
  ocl_data_t rd_data;
  led_t      led_shadow;

  // Bus slave
  ocl_slave u_ocl_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rready          (rready),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data)
  );

  // Hello world and LED shadow registers
  hello_world_reg #(
    .LED_W (LED_W)
  ) u_hello_world_reg (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .led_shadow      (led_shadow)
  );

  // DIP sync and LED mask
  vled_status #(
    .LED_W (LED_W)
  ) u_vled_status (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .led_shadow      (led_shadow),
    .vdip            (vdip),
    .vled            (vled)
  );

endmodule

// File: tb/clk_gen.sv
// Clock and reset generator

`timescale 1ns/1ps

module clk_gen #(
  parameter int HALF_PERIOD_NS = 50,
  parameter int RESET_CYCLES   = 5
) (
  output logic clk_main_a0,
  output logic rst_main_n_sync
);

  // 100 ns period
  initial
  begin
    clk_main_a0 = 1'b0;
    forever #(HALF_PERIOD_NS) clk_main_a0 = ~clk_main_a0;
  end

  // Reset held low over the first rising edges, released on a falling edge
  initial
  begin
    rst_main_n_sync = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    rst_main_n_sync = 1'b1;
  end

endmodule

// File: tb/cl_hello_asserts.sv
// Bus slave handshake assertions

`timescale 1ns/1ps

module cl_hello_asserts
  import cl_hello_pkg::*;
(
  input logic      clk_main_a0,
  input logic      rst_main_n_sync,
  input logic      bvalid,
  input logic      bready,
  input logic      rvalid,
  input logic      rready,
  input ocl_data_t rdata,
  input logic      wr_en,
  input wr_state_e wr_state
);

  // Failure tally, read by the testbench top
  int unsigned fail_count = 0;

  // Write response held until bready
  bvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (bvalid && !bready) |=> bvalid)
  else
  begin
    $error("bvalid dropped before the response was accepted");
    fail_count++;
  end

  // Read response and its data held until rready
  rvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (rvalid && !rready) |=> (rvalid && $stable(rdata)))
  else
  begin
    $error("rvalid or rdata changed before the read was accepted");
    fail_count++;
  end

  // Strobe lasts one cycle and hands over to the response
  wr_en_state: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    wr_en |=> ((wr_state == WR_RESP) && !wr_en))
  else
  begin
    $error("wr_en was not followed by a single WR_RESP cycle");
    fail_count++;
  end

endmodule

// File: tb/ocl_checker.sv
// Bus and LED checker

`timescale 1ns/1ps

module ocl_checker
  import cl_hello_pkg::*;
(
  input  logic      clk_main_a0,
  input  logic      rst_main_n_sync,
  input  logic      awvalid,
  input  ocl_addr_t awaddr,
  input  logic      awready,
  input  logic      wvalid,
  input  ocl_data_t wdata,
  input  logic      wready,
  input  logic      arvalid,
  input  ocl_addr_t araddr,
  input  logic      arready,
  input  logic      rvalid,
  input  ocl_data_t rdata,
  input  logic      rready,
  input  led_t      vdip,
  input  led_t      vled,
  input  int        test_id,
  input  logic      tests_done,
  output int        error_count
);

  // Reference state of the register file
  ocl_data_t model_hello  = '0;
  ocl_addr_t aw_addr_seen = '0;
  ocl_addr_t ar_addr_seen = '0;
  ocl_data_t expected     = '0;
  led_t      dip_last     = '0;
  int        stable_cycles = 0;
  int        cur_test      = 0;
  int        test_checks   = 0;
  int        test_errors   = 0;
  int        total_checks  = 0;
  int        total_tests   = 0;
  int        errors        = 0;
  bit        finished      = 1'b0;

  assign error_count = errors;

  // ------------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------------
  // Read value for an address, given the stored hello world word
  function automatic ocl_data_t ref_read(input ocl_addr_t addr, input ocl_data_t hello);
    ocl_data_t swapped;
    begin
      // Byte i of the result is byte 3-i of the register
      for (int i = 0; i < 4; i++)
        swapped[8*i +: 8] = hello[8*(3-i) +: 8];
      if (addr == HELLO_WORLD_REG_ADDR)
        return swapped;
      else if (addr == VLED_REG_ADDR)
        return {16'h0000, hello[15:0]};
      return '0;
    end
  endfunction

  // LED pattern once the DIP sync has settled
  function automatic led_t ref_led(input ocl_data_t hello, input led_t dip);
    return hello[15:0] & dip;
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1:       return "reset values";
      2:       return "byte swap";
      3:       return "LED shadow read";
      4:       return "DIP mask";
      5:       return "unmapped addresses";
      6:       return "back-pressure";
      default: return "unknown";
    endcase
  endfunction

  task automatic report_test();
    $display("Test %0d (%s): %0d checks, %0d errors",
             cur_test, test_name(cur_test), test_checks, test_errors);
    total_tests  += 1;
    total_checks += test_checks;
    test_checks  = 0;
    test_errors  = 0;
  endtask

  // ------------------------------------------------------------------------
  // Monitor and compare
  // ------------------------------------------------------------------------
  always @(posedge clk_main_a0)
  begin
    // Test boundaries from the testbench top
    if (test_id != cur_test)
    begin
      if (cur_test != 0)
        report_test();
      cur_test = test_id;
    end

    if (!rst_main_n_sync)
    begin
      model_hello   = '0;
      stable_cycles = 0;
      dip_last      = '0;
    end
    else if (!finished)
    begin
      // Write tracking, address then data beat
      if (awvalid && awready)
        aw_addr_seen = awaddr;
      if (vdip != dip_last)
        stable_cycles = 0;
      else if (stable_cycles < 16)
        stable_cycles++;
      dip_last = vdip;
      if (wvalid && wready)
      begin
        if (aw_addr_seen == HELLO_WORLD_REG_ADDR)
          model_hello = wdata;
        stable_cycles = 0;
      end

      // Completed reads
      if (arvalid && arready)
        ar_addr_seen = araddr;
      if (rvalid && rready)
      begin
        expected = ref_read(ar_addr_seen, model_hello);
        test_checks++;
        if (rdata !== expected)
        begin
          $display("ERROR at %0t: read of %h returned %h, expected %h",
                   $time, ar_addr_seen, rdata, expected);
          test_errors++;
          errors++;
        end
      end

      // Settled LEDs, 3 edges of latency plus margin
      if (stable_cycles >= 4)
      begin
        test_checks++;
        if (vled !== ref_led(model_hello, vdip))
        begin
          $display("ERROR at %0t: vled is %h, expected %h with vdip %h",
                   $time, vled, ref_led(model_hello, vdip), vdip);
          test_errors++;
          errors++;
        end
      end
    end

    if (tests_done && !finished)
    begin
      report_test();
      $display("Totals: %0d tests, %0d checks, %0d errors", total_tests, total_checks, errors);
      finished = 1'b1;
    end
  end

endmodule

// File: tb/tb_cl_hello.sv
// Hello world testbench

`timescale 1ns/1ps

module tb_cl_hello;
  import cl_hello_pkg::*;

  // 6 tests x 40 transactions x 20 cycles
  localparam int TIMEOUT_CYCLES = 6 * 40 * 20;

  logic        clk_main_a0;
  logic        rst_main_n_sync;
  logic        awvalid;
  ocl_addr_t   awaddr;
  logic        awready;
  logic        wvalid;
  ocl_data_t   wdata;
  logic        wready;
  logic        bvalid;
  logic        bready;
  logic        arvalid;
  ocl_addr_t   araddr;
  logic        arready;
  logic        rvalid;
  ocl_data_t   rdata;
  logic        rready;
  led_t        vdip;
  led_t        vled;
  int          test_id;
  logic        tests_done;
  int          error_count;
  int unsigned resp_delay_max;
  int          cycle_count;
  int unsigned assert_fails;

  clk_gen u_clk_gen (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync)
  );

  cl_hello_top UUT (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rready          (rready),
    .vdip            (vdip),
    .vled            (vled)
  );

  ocl_checker u_checker (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rready          (rready),
    .vdip            (vdip),
    .vled            (vled),
    .test_id         (test_id),
    .tests_done      (tests_done),
    .error_count     (error_count)
  );

  // Handshake assertions on every bus slave
  bind ocl_slave cl_hello_asserts u_asserts (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .bvalid          (bvalid),
    .bready          (bready),
    .rvalid          (rvalid),
    .rready          (rready),
    .rdata           (rdata),
    .wr_en           (wr_en),
    .wr_state        (wr_state)
  );

  // ------------------------------------------------------------------------
  // Bus tasks, drive on falling edges
  // ------------------------------------------------------------------------
  // Ready is sampled at the rising edge, before the DUT state moves
  task automatic bus_write(input ocl_addr_t addr, input ocl_data_t data);
    int unsigned delay;
    begin
      delay = $urandom_range(resp_delay_max);
      @(negedge clk_main_a0);
      awvalid = 1'b1;
      awaddr  = addr;
      @(posedge clk_main_a0);
      while (!awready)
        @(posedge clk_main_a0);
      @(negedge clk_main_a0);
      awvalid = 1'b0;
      wvalid  = 1'b1;
      wdata   = data;
      @(posedge clk_main_a0);
      while (!wready)
        @(posedge clk_main_a0);
      @(negedge clk_main_a0);
      wvalid = 1'b0;
      // Response, with bready held back for a while
      while (!bvalid)
        @(negedge clk_main_a0);
      repeat (delay) @(negedge clk_main_a0);
      bready = 1'b1;
      @(negedge clk_main_a0);
      bready = 1'b0;
    end
  endtask

  task automatic bus_read(input ocl_addr_t addr);
    int unsigned delay;
    begin
      delay = $urandom_range(resp_delay_max);
      @(negedge clk_main_a0);
      arvalid = 1'b1;
      araddr  = addr;
      @(posedge clk_main_a0);
      while (!arready)
        @(posedge clk_main_a0);
      @(negedge clk_main_a0);
      arvalid = 1'b0;
      while (!rvalid)
        @(negedge clk_main_a0);
      repeat (delay) @(negedge clk_main_a0);
      rready = 1'b1;
      @(negedge clk_main_a0);
      rready = 1'b0;
    end
  endtask

  task automatic start_test(input int id);
    @(negedge clk_main_a0);
    test_id = id;
  endtask

  task automatic set_dip(input led_t value);
    @(negedge clk_main_a0);
    vdip = value;
  endtask

  // Random word aligned address outside the register map
  function automatic ocl_addr_t unmapped_addr();
    ocl_addr_t addr;
    begin
      addr = $urandom & 32'hffff_fffc;
      if ((addr == HELLO_WORLD_REG_ADDR) || (addr == VLED_REG_ADDR))
        addr = addr + 32'h10;
      return addr;
    end
  endfunction

  // ------------------------------------------------------------------------
  // Timeout
  // ------------------------------------------------------------------------
  initial
  begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge clk_main_a0);
      cycle_count++;
    end
    $display("Timeout: tests still running after %0d clock cycles", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  // ------------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------------
  initial
  begin
    awvalid        = 1'b0;
    awaddr         = '0;
    wvalid         = 1'b0;
    wdata          = '0;
    bready         = 1'b0;
    arvalid        = 1'b0;
    araddr         = '0;
    rready         = 1'b0;
    vdip           = '0;
    test_id        = 0;
    tests_done     = 1'b0;
    resp_delay_max = 0;
    void'($urandom(32'h3b00_d5c2));

    @(posedge rst_main_n_sync);

    // Registers and LEDs come out of reset at zero
    start_test(1);
    bus_read(HELLO_WORLD_REG_ADDR);
    bus_read(VLED_REG_ADDR);
    repeat (6) @(negedge clk_main_a0);

    start_test(2);
    repeat (20)
    begin
      bus_write(HELLO_WORLD_REG_ADDR, $urandom);
      bus_read(HELLO_WORLD_REG_ADDR);
    end

    start_test(3);
    repeat (15)
    begin
      bus_write(HELLO_WORLD_REG_ADDR, $urandom);
      bus_read(VLED_REG_ADDR);
    end

    // DIP values held 4 to 8 cycles after each write
    start_test(4);
    repeat (10)
    begin
      set_dip(led_t'($urandom));
      bus_write(HELLO_WORLD_REG_ADDR, $urandom);
      repeat ($urandom_range(8, 4)) @(negedge clk_main_a0);
    end
    set_dip(16'hffff);

    // Unmapped writes must leave the hello world word alone
    start_test(5);
    repeat (10)
    begin
      bus_write(unmapped_addr(), $urandom);
      bus_read(unmapped_addr());
      bus_read(HELLO_WORLD_REG_ADDR);
    end

    start_test(6);
    resp_delay_max = 8;
    repeat (10)
    begin
      bus_write(HELLO_WORLD_REG_ADDR, $urandom);
      bus_read(HELLO_WORLD_REG_ADDR);
      bus_read(VLED_REG_ADDR);
      bus_read(unmapped_addr());
    end
    repeat (6) @(negedge clk_main_a0);

    // Let the checker close the last test
    tests_done = 1'b1;
    @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    assert_fails = UUT.u_ocl_slave.u_asserts.fail_count;
    if (assert_fails != 0)
      $display("%0d bus handshake assertions did not hold", assert_fails);
    if ((error_count == 0) && (assert_fails == 0))
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: vlog.f
common/cl_hello_pkg.sv
ocl/ocl_slave.sv
src/hello_world_reg.sv
src/vled_status.sv
src/cl_hello_top.sv
tb/clk_gen.sv
tb/cl_hello_asserts.sv
tb/ocl_checker.sv
tb/tb_cl_hello.sv

// File: Bender.yml
package:
  name: cl_hello

sources:
  - files:
      - common/cl_hello_pkg.sv
      - ocl/ocl_slave.sv
      - src/hello_world_reg.sv
      - src/vled_status.sv
      - src/cl_hello_top.sv
  - target: test
    files:
      - tb/clk_gen.sv
      - tb/cl_hello_asserts.sv
      - tb/ocl_checker.sv
      - tb/tb_cl_hello.sv
